// File: source/core_pkg.sv
package core_pkg;

  localparam int XLEN = 32;
  localparam int REG_ADDR_W = 5;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // ADDI x0, x0, 0
  localparam word_t NOP_INST = 32'h0000_0013;
  // ECALL stops the core
  localparam word_t HALT_INST = 32'h0000_0073;

  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    SYSTEM = 7'b1110011
  } opcode_e;

  // funct3 of the OP and OP-IMM groups
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
  } alu_op_e;

  // Also the encoding of the dwrite and dread ports
  typedef enum logic [1:0] {
    MEM_NONE = 2'd0,
    MEM_BYTE = 2'd1,
    MEM_HALF = 2'd2,
    MEM_WORD = 2'd3
  } mem_size_e;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    opcode_e     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_e    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_addr_t   rd;
    opcode_e     opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    u_fmt_t u;
  } inst_u;

  typedef struct packed {
    alu_op_e   alu_op;
    logic      alu_src_imm;
    logic      alu_src_upper;
    logic      reg_write;
    mem_size_e mem_read;
    mem_size_e mem_write;
    logic      load_signed;
    logic      halt;
  } ctrl_t;

  localparam ctrl_t CTRL_BUBBLE = '{
    alu_op: ALU_ADD, alu_src_imm: 1'b0, alu_src_upper: 1'b0, reg_write: 1'b0,
    mem_read: MEM_NONE, mem_write: MEM_NONE, load_signed: 1'b0, halt: 1'b0
  };

  typedef struct packed {
    ctrl_t     ctrl;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     rdat1;
    word_t     rdat2;
    word_t     imm;
  } dec_exe_t;

  typedef struct packed {
    ctrl_t     ctrl;
    reg_addr_t rd;
    word_t     alu_out;
    word_t     sdata;
  } exe_mem_t;

  typedef struct packed {
    ctrl_t     ctrl;
    reg_addr_t rd;
    word_t     alu_out;
    word_t     dload;
  } mem_wb_t;

  typedef struct packed {
    reg_addr_t rd;
    logic      reg_write;
    word_t     value;
  } fwd_t;

endpackage

// File: source/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import core_pkg::*; #(
  parameter word_t PC_INIT = '0
) (
  input  logic  clk,
  input  logic  nrst,
  input  logic  stall,
  output word_t iaddr,
  input  word_t iload,
  output inst_u f2d_inst
);

  word_t pc;

  // Instruction memory answers in the same cycle
  assign iaddr = pc;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      pc       <= PC_INIT;
      f2d_inst <= NOP_INST;
    end else if (!stall) begin
      pc       <= pc + word_t'(4);
      f2d_inst <= iload;
    end
  end

  // While stalled, PC and fetched word both hold

endmodule

// File: source/register_file.sv
`timescale 1ns/1ps

module register_file import core_pkg::*; (
  input  logic      clk,
  input  logic      nrst,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  output word_t     rdat1,
  output word_t     rdat2,
  input  logic      wen,
  input  reg_addr_t wsel,
  input  word_t     wdat
);

  word_t regs [32];

  // x0 reads zero, and a same-cycle write is passed straight through
  function automatic word_t read_port(reg_addr_t sel, word_t stored, logic we,
                                      reg_addr_t wa, word_t wd);
    if (sel == '0) begin
      return '0;
    end
    if (we && wa == sel) begin
      return wd;
    end
    return stored;
  endfunction

  assign rdat1 = read_port(rs1, regs[rs1], wen, wsel, wdat);
  assign rdat2 = read_port(rs2, regs[rs2], wen, wsel, wdat);

  always_ff @(posedge clk) begin
    if (!nrst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && wsel != '0) begin
      regs[wsel] <= wdat;
    end
  end

endmodule

// File: source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import core_pkg::*; (
  input  logic      clk,
  input  logic      nrst,
  input  inst_u     f2d_inst,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  input  word_t     rdat1,
  input  word_t     rdat2,
  output logic      stall,
  output dec_exe_t  d2e
);

  inst_u    inst;
  ctrl_t    ctrl;
  word_t    imm;
  logic     use_rs1;
  logic     use_rs2;
  logic     halted;
  dec_exe_t d2e_next;

  function automatic mem_size_e size_of(logic [1:0] f3);
    case (f3)
      2'd0:    return MEM_BYTE;
      2'd1:    return MEM_HALF;
      default: return MEM_WORD;
    endcase
  endfunction

  assign rs1 = f2d_inst.r.rs1;
  assign rs2 = f2d_inst.r.rs2;

  // Load in execute whose result is needed right now
  always_comb begin
    use_rs1 = f2d_inst.r.opcode != LUI;
    use_rs2 = f2d_inst.r.opcode inside {OP, STORE};
    stall = (d2e.ctrl.mem_read != MEM_NONE) && (d2e.rd != '0) &&
            ((use_rs1 && d2e.rd == rs1) || (use_rs2 && d2e.rd == rs2));
  end

  // Everything after a halt is squashed
  assign inst = (stall || halted) ? inst_u'(NOP_INST) : f2d_inst;

  always_comb begin
    ctrl = CTRL_BUBBLE;
    imm  = {{20{inst.i.imm[11]}}, inst.i.imm};
    case (inst.r.opcode)
      OP, OP_IMM: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = inst.r.opcode == OP_IMM;
        case (inst.r.funct3)
          F3_ADD: begin
            // SUB only exists in the register form
            if (inst.r.opcode == OP && inst.r.funct7[5]) begin
              ctrl.alu_op = ALU_SUB;
            end
          end
          F3_SLL:  ctrl.alu_op = ALU_SLL;
          F3_SLT:  ctrl.alu_op = ALU_SLT;
          F3_SLTU: ctrl.alu_op = ALU_SLTU;
          F3_XOR:  ctrl.alu_op = ALU_XOR;
          F3_SR:   ctrl.alu_op = inst.r.funct7[5] ? ALU_SRA : ALU_SRL;
          F3_OR:   ctrl.alu_op = ALU_OR;
          default: ctrl.alu_op = ALU_AND;
        endcase
      end
      LUI: begin
        ctrl.reg_write     = 1'b1;
        ctrl.alu_src_imm   = 1'b1;
        ctrl.alu_src_upper = 1'b1;
        imm = {inst.u.imm, 12'b0};
      end
      LOAD: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_read    = size_of(inst.i.funct3[1:0]);
        ctrl.load_signed = !inst.i.funct3[2];
      end
      STORE: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_write   = size_of(inst.s.funct3[1:0]);
        imm = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
      end
      SYSTEM: ctrl.halt = inst == HALT_INST;
      default: ctrl = CTRL_BUBBLE;
    endcase
  end

  always_comb begin
    d2e_next.ctrl  = ctrl;
    d2e_next.rs1   = inst.r.rs1;
    d2e_next.rs2   = inst.r.rs2;
    d2e_next.rd    = ctrl.reg_write ? inst.r.rd : '0;
    d2e_next.rdat1 = (stall || halted) ? '0 : rdat1;
    d2e_next.rdat2 = (stall || halted) ? '0 : rdat2;
    d2e_next.imm   = imm;
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      d2e.ctrl <= CTRL_BUBBLE;
      d2e.rd   <= '0;
      halted   <= 1'b0;
    end else begin
      d2e    <= d2e_next;
      halted <= halted | ctrl.halt;
    end
  end

endmodule

// File: source/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import core_pkg::*; (
  input  logic     clk,
  input  logic     nrst,
  input  dec_exe_t d2e,
  input  fwd_t     mem_fwd,
  input  fwd_t     wb_fwd,
  output exe_mem_t e2m
);

  word_t    op1;
  word_t    op2;
  word_t    alu_a;
  word_t    alu_b;
  word_t    alu_out;
  exe_mem_t e2m_next;

  // Memory stage is younger, so it takes priority over writeback
  function automatic word_t pick_operand(reg_addr_t rs, word_t rdat, fwd_t near, fwd_t far);
    if (near.reg_write && near.rd != '0 && near.rd == rs) begin
      return near.value;
    end
    if (far.reg_write && far.rd != '0 && far.rd == rs) begin
      return far.value;
    end
    return rdat;
  endfunction

  assign op1 = pick_operand(d2e.rs1, d2e.rdat1, mem_fwd, wb_fwd);
  assign op2 = pick_operand(d2e.rs2, d2e.rdat2, mem_fwd, wb_fwd);

  // LUI adds the upper immediate to zero
  assign alu_a = d2e.ctrl.alu_src_upper ? '0 : op1;
  assign alu_b = d2e.ctrl.alu_src_imm ? d2e.imm : op2;

  always_comb begin
    case (d2e.ctrl.alu_op)
      ALU_SUB:  alu_out = alu_a - alu_b;
      ALU_AND:  alu_out = alu_a & alu_b;
      ALU_OR:   alu_out = alu_a | alu_b;
      ALU_XOR:  alu_out = alu_a ^ alu_b;
      ALU_SLT:  alu_out = word_t'($signed(alu_a) < $signed(alu_b));
      ALU_SLTU: alu_out = word_t'(alu_a < alu_b);
      ALU_SLL:  alu_out = alu_a << alu_b[4:0];
      ALU_SRL:  alu_out = alu_a >> alu_b[4:0];
      ALU_SRA:  alu_out = word_t'($signed(alu_a) >>> alu_b[4:0]);
      default:  alu_out = alu_a + alu_b;
    endcase
  end

  always_comb begin
    e2m_next.ctrl    = d2e.ctrl;
    e2m_next.rd      = d2e.rd;
    e2m_next.alu_out = alu_out;
    // Store data may itself have been forwarded
    e2m_next.sdata   = op2;
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      e2m.ctrl <= CTRL_BUBBLE;
      e2m.rd   <= '0;
    end else begin
      e2m <= e2m_next;
    end
  end

endmodule

// File: source/memory_stage.sv
`timescale 1ns/1ps

module memory_stage import core_pkg::*; (
  input  logic      clk,
  input  logic      nrst,
  input  exe_mem_t  e2m,
  output word_t     daddr,
  output word_t     dstore,
  output mem_size_e dwrite,
  output mem_size_e dread,
  input  word_t     dload,
  output fwd_t      mem_fwd,
  output mem_wb_t   m2w
);

  mem_wb_t m2w_next;

  assign daddr  = e2m.alu_out;
  assign dwrite = e2m.ctrl.mem_write;
  assign dread  = e2m.ctrl.mem_read;

  // Put the store data into the lane picked by the low address bits
  always_comb begin
    case (e2m.ctrl.mem_write)
      MEM_BYTE: dstore = word_t'(e2m.sdata[7:0]) << {e2m.alu_out[1:0], 3'b000};
      MEM_HALF: dstore = word_t'(e2m.sdata[15:0]) << {e2m.alu_out[1], 4'b0000};
      default:  dstore = e2m.sdata;
    endcase
  end

  // The load-use stall keeps a load here from being consumed
  always_comb begin
    mem_fwd.rd        = e2m.rd;
    mem_fwd.reg_write = e2m.ctrl.reg_write;
    mem_fwd.value     = e2m.alu_out;
  end

  always_comb begin
    m2w_next.ctrl    = e2m.ctrl;
    m2w_next.rd      = e2m.rd;
    m2w_next.alu_out = e2m.alu_out;
    m2w_next.dload   = dload;
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      m2w.ctrl <= CTRL_BUBBLE;
      m2w.rd   <= '0;
    end else begin
      m2w <= m2w_next;
    end
  end

endmodule

// File: source/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage import core_pkg::*; (
  input  mem_wb_t   m2w,
  output logic      wen,
  output reg_addr_t wsel,
  output word_t     wdat,
  output fwd_t      wb_fwd
);

  logic [7:0]  lane_byte;
  logic [15:0] lane_half;
  word_t       result;

  // Byte and half lanes follow the address of the access
  assign lane_byte = m2w.dload[{m2w.alu_out[1:0], 3'b000} +: 8];
  assign lane_half = m2w.dload[{m2w.alu_out[1], 4'b0000} +: 16];

  always_comb begin
    case (m2w.ctrl.mem_read)
      MEM_BYTE: begin
        result = m2w.ctrl.load_signed ? {{24{lane_byte[7]}}, lane_byte} :
                                        {24'b0, lane_byte};
      end
      MEM_HALF: begin
        result = m2w.ctrl.load_signed ? {{16{lane_half[15]}}, lane_half} :
                                        {16'b0, lane_half};
      end
      MEM_WORD: result = m2w.dload;
      default:  result = m2w.alu_out;
    endcase
  end

  assign wen  = m2w.ctrl.reg_write;
  assign wsel = m2w.rd;
  assign wdat = result;

  // Same value goes to execute for distance-two operands
  always_comb begin
    wb_fwd.rd        = m2w.rd;
    wb_fwd.reg_write = m2w.ctrl.reg_write;
    wb_fwd.value     = result;
  end

endmodule

// File: source/pipeline_top.sv
`timescale 1ns/1ps

module pipeline_top import core_pkg::*; #(
  parameter word_t PC_INIT = '0
) (
  input  logic      clk,
  input  logic      nrst,
  output word_t     iaddr,
  input  word_t     iload,
  output word_t     daddr,
  output mem_size_e dwrite,
  output word_t     dstore,
  output mem_size_e dread,
  input  word_t     dload,
  output logic      halt
);

  inst_u     f2d_inst;
  logic      stall;
  reg_addr_t rs1;
  reg_addr_t rs2;
  word_t     rdat1;
  word_t     rdat2;
  dec_exe_t  d2e;
  exe_mem_t  e2m;
  mem_wb_t   m2w;
  fwd_t      mem_fwd;
  fwd_t      wb_fwd;
  logic      wen;
  reg_addr_t wsel;
  word_t     wdat;

  fetch_stage #(.PC_INIT(PC_INIT)) u_fetch (
    .clk(clk), .nrst(nrst), .stall(stall),
    .iaddr(iaddr), .iload(iload), .f2d_inst(f2d_inst)
  );

  decode_stage u_decode (
    .clk(clk), .nrst(nrst), .f2d_inst(f2d_inst), .rs1(rs1), .rs2(rs2),
    .rdat1(rdat1), .rdat2(rdat2), .stall(stall), .d2e(d2e)
  );

  register_file u_regs (
    .clk(clk), .nrst(nrst), .rs1(rs1), .rs2(rs2), .rdat1(rdat1), .rdat2(rdat2),
    .wen(wen), .wsel(wsel), .wdat(wdat)
  );

  execute_stage u_execute (
    .clk(clk), .nrst(nrst), .d2e(d2e), .mem_fwd(mem_fwd), .wb_fwd(wb_fwd), .e2m(e2m)
  );

  memory_stage u_memory (
    .clk(clk), .nrst(nrst), .e2m(e2m), .daddr(daddr), .dstore(dstore),
    .dwrite(dwrite), .dread(dread), .dload(dload), .mem_fwd(mem_fwd), .m2w(m2w)
  );

  writeback_stage u_writeback (
    .m2w(m2w), .wen(wen), .wsel(wsel), .wdat(wdat), .wb_fwd(wb_fwd)
  );

  // Sticky until the next reset
  always_ff @(posedge clk) begin
    if (!nrst) begin
      halt <= 1'b0;
    end else if (m2w.ctrl.halt) begin
      halt <= 1'b1;
    end
  end

endmodule

// File: tb/pipeline_checker.sv
`timescale 1ns/1ps

module pipeline_checker import core_pkg::*; (
  input logic      clk,
  input logic      nrst,
  input word_t     iaddr,
  input mem_size_e dwrite,
  input mem_size_e dread,
  input logic      halt
);

  // One access per cycle on the data port
  assert property (@(posedge clk) disable iff (!nrst)
    !(dwrite != MEM_NONE && dread != MEM_NONE))
    else $error("data port read and write active in the same cycle");

  // Halt is sticky until reset
  assert property (@(posedge clk) nrst && $past(nrst) && $past(halt) |-> halt)
    else $error("halt dropped without a reset");

  assert property (@(posedge clk) !$past(nrst) && nrst |-> dwrite == MEM_NONE)
    else $error("store on the data port right after reset");

  assert property (@(posedge clk) disable iff (!nrst) iaddr[1:0] == 2'b00)
    else $error("instruction address not word aligned");

endmodule

bind pipeline_top pipeline_checker u_checker (
  .clk(clk), .nrst(nrst), .iaddr(iaddr), .dwrite(dwrite), .dread(dread), .halt(halt)
);

// File: tb/pipeline_tb.sv
`timescale 1ns/1ps

module pipeline_tb import core_pkg::*; ();

  localparam word_t PC_INIT = 32'h0000_1000;
  localparam int NTEST = 6;
  localparam int MAXI = 128;
  localparam int MAXS = 32;

  logic      clk;
  logic      nrst;
  word_t     iaddr;
  word_t     iload;
  word_t     daddr;
  word_t     dstore;
  word_t     dload;
  mem_size_e dwrite;
  mem_size_e dread;
  logic      halt;

  // Per test: program slice and the stores it must produce, in order
  word_t     prog [NTEST][MAXI];
  int        prog_len [NTEST];
  word_t     exp_addr [NTEST][MAXS];
  mem_size_e exp_size [NTEST][MAXS];
  word_t     exp_data [NTEST][MAXS];
  int        exp_cnt [NTEST];
  // Reads the data port must show, in order
  word_t     exp_raddr [NTEST][MAXS];
  mem_size_e exp_rsize [NTEST][MAXS];
  int        exp_rcnt [NTEST];

  logic [7:0] golden [4096];
  logic [7:0] dmem [4096];
  word_t      got_addr [$];
  mem_size_e  got_size [$];
  word_t      got_data [$];
  word_t      got_raddr [$];
  mem_size_e  got_rsize [$];
  int         cur;
  int         st_addr;
  int         limit;
  word_t      iidx;

  pipeline_top #(.PC_INIT(PC_INIT)) UUT (
    .clk(clk), .nrst(nrst), .iaddr(iaddr), .iload(iload), .daddr(daddr),
    .dwrite(dwrite), .dstore(dstore), .dread(dread), .dload(dload), .halt(halt)
  );

  // Instruction memory, NOPs past the end of the slice
  assign iidx  = (iaddr - PC_INIT) >> 2;
  assign iload = (iidx < word_t'(prog_len[cur])) ? prog[cur][iidx[6:0]] : NOP_INST;

  assign dload = {dmem[{daddr[11:2], 2'd3}], dmem[{daddr[11:2], 2'd2}],
                  dmem[{daddr[11:2], 2'd1}], dmem[{daddr[11:2], 2'd0}]};

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Data port is settled mid-cycle
  always @(negedge clk) begin
    if (!nrst) begin
      dmem = golden;
      got_addr.delete();
      got_size.delete();
      got_data.delete();
      got_raddr.delete();
      got_rsize.delete();
    end else begin
      if (dread != MEM_NONE) begin
        got_raddr.push_back(daddr);
        got_rsize.push_back(dread);
      end
      if (dwrite != MEM_NONE) begin
        got_addr.push_back(daddr);
        got_size.push_back(dwrite);
        got_data.push_back(dstore);
        for (int i = 0; i < 4; i++) begin
          if (dwrite == MEM_WORD || (dwrite == MEM_HALF && i[1] == daddr[1]) ||
              (dwrite == MEM_BYTE && i[1:0] == daddr[1:0])) begin
            dmem[{daddr[11:2], i[1:0]}] = dstore[8*i +: 8];
          end
        end
      end
    end
  end

  function automatic word_t xorshift(word_t x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // RV32I encodings
  function automatic word_t enc_r(int f7, int rs2, int rs1, int f3, int rd, opcode_e op);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic word_t enc_i(int imm, int rs1, int f3, int rd, opcode_e op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic word_t enc_s(int imm, int rs2, int rs1, int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], STORE};
  endfunction

  function automatic word_t enc_u(int imm20, int rd);
    return {imm20[19:0], rd[4:0], LUI};
  endfunction

  function automatic word_t golden_word(int a);
    int b;
    b = a & ~3;
    return {golden[b+3], golden[b+2], golden[b+1], golden[b]};
  endfunction

  // Lane picked by the address, then sign or zero extension
  function automatic word_t load_value(int a, mem_size_e s, bit sgn);
    word_t       w;
    logic [7:0]  b;
    logic [15:0] h;
    w = golden_word(a);
    b = w[8*(a%4) +: 8];
    h = w[16*((a/2)%2) +: 16];
    case (s)
      MEM_BYTE: return sgn ? {{24{b[7]}}, b} : {24'h0, b};
      MEM_HALF: return sgn ? {{16{h[15]}}, h} : {16'h0, h};
      default:  return w;
    endcase
  endfunction

  task automatic check(string name, word_t got, word_t expv);
    if (got !== expv) begin
      $display("Fail %s in test %0d: got %h, expected %h", name, cur, got, expv);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic emit(word_t w);
    prog[cur][prog_len[cur]] = w;
    prog_len[cur]++;
  endtask

  task automatic expect_store(word_t a, mem_size_e s, word_t d);
    exp_addr[cur][exp_cnt[cur]] = a;
    exp_size[cur][exp_cnt[cur]] = s;
    exp_data[cur][exp_cnt[cur]] = d;
    exp_cnt[cur]++;
  endtask

  // Load from an absolute address and note the read it makes
  task automatic load_into(int rd, int a, int f3, mem_size_e s);
    emit(enc_i(a, 0, f3, rd, LOAD));
    exp_raddr[cur][exp_rcnt[cur]] = a;
    exp_rsize[cur][exp_rcnt[cur]] = s;
    exp_rcnt[cur]++;
  endtask

  task automatic store_word(int rs, word_t v);
    emit(enc_s(st_addr, rs, 0, 2));
    expect_store(word_t'(st_addr), MEM_WORD, v);
    st_addr += 4;
  endtask

  task automatic load_const(int rd, word_t v);
    word_t hi;
    hi = (v + 32'h800) >> 12;
    emit(enc_u(hi, rd));
    emit(enc_i(v, rd, 0, rd, OP_IMM));
  endtask

  // Result in x3, stored after gap NOPs
  task automatic alu_case(word_t inst, word_t v, int gap);
    emit(inst);
    repeat (gap) emit(NOP_INST);
    store_word(3, v);
  endtask

  task automatic build_tests();
    word_t a;
    word_t b;
    word_t c;
    word_t m;
    a = 32'h8765_4321;
    b = 32'h0000_0013;
    c = 32'h1122_a3b4;
    for (int t = 0; t < NTEST; t++) begin
      prog_len[t] = 0;
      exp_cnt[t] = 0;
      exp_rcnt[t] = 0;
    end
    // Tests 0 to 2 run the ALU set at distance 1, 2 and 3
    for (int g = 0; g < 3; g++) begin
      cur = g;
      st_addr = 'h100;
      load_const(1, a);
      load_const(2, b);
      alu_case(enc_r(0, 2, 1, 0, 3, OP), a + b, g);
      alu_case(enc_r('h20, 2, 1, 0, 3, OP), a - b, g);
      alu_case(enc_r(0, 2, 1, 1, 3, OP), a << b[4:0], g);
      alu_case(enc_r(0, 2, 1, 2, 3, OP), word_t'($signed(a) < $signed(b)), g);
      alu_case(enc_r(0, 2, 1, 3, 3, OP), word_t'(a < b), g);
      alu_case(enc_r(0, 1, 2, 3, 3, OP), word_t'(b < a), g);
      alu_case(enc_r(0, 2, 1, 4, 3, OP), a ^ b, g);
      alu_case(enc_r(0, 2, 1, 5, 3, OP), a >> b[4:0], g);
      alu_case(enc_r('h20, 2, 1, 5, 3, OP), word_t'($signed(a) >>> b[4:0]), g);
      alu_case(enc_r(0, 2, 1, 6, 3, OP), a | b, g);
      alu_case(enc_r(0, 2, 1, 7, 3, OP), a & b, g);
      alu_case(enc_i(-7, 1, 0, 3, OP_IMM), a - 7, g);
      alu_case(enc_i(-1, 1, 2, 3, OP_IMM), word_t'($signed(a) < -1), g);
      alu_case(enc_i(-1, 1, 3, 3, OP_IMM), word_t'(a < 32'hffff_ffff), g);
      alu_case(enc_i('h7f0, 1, 4, 3, OP_IMM), a ^ 32'h0000_07f0, g);
      alu_case(enc_i('h80f, 1, 6, 3, OP_IMM), a | 32'hffff_f80f, g);
      alu_case(enc_i('h0ff, 1, 7, 3, OP_IMM), a & 32'h0000_00ff, g);
      alu_case(enc_i(5, 1, 1, 3, OP_IMM), a << 5, g);
      alu_case(enc_i(5, 1, 5, 3, OP_IMM), a >> 5, g);
      alu_case(enc_i('h405, 1, 5, 3, OP_IMM), word_t'($signed(a) >>> 5), g);
      alu_case(enc_u('habcde, 3), 32'habcd_e000, g);
      // Chain of dependent results
      emit(enc_i(5, 1, 0, 6, OP_IMM));
      repeat (g) emit(NOP_INST);
      emit(enc_r(0, 2, 6, 4, 7, OP));
      repeat (g) emit(NOP_INST);
      store_word(7, (a + 5) ^ b);
      emit(HALT_INST);
    end
    // Loads used by the very next instruction
    cur = 3;
    st_addr = 'h100;
    for (int l = 0; l < 4; l++) begin
      load_into(8, 'h200 + l, 0, MEM_BYTE);
      store_word(8, load_value('h200 + l, MEM_BYTE, 1'b1));
      load_into(8, 'h204 + l, 4, MEM_BYTE);
      store_word(8, load_value('h204 + l, MEM_BYTE, 1'b0));
    end
    for (int l = 0; l < 4; l += 2) begin
      load_into(8, 'h208 + l, 1, MEM_HALF);
      store_word(8, load_value('h208 + l, MEM_HALF, 1'b1));
      load_into(8, 'h20c + l, 5, MEM_HALF);
      store_word(8, load_value('h20c + l, MEM_HALF, 1'b0));
    end
    load_into(8, 'h210, 2, MEM_WORD);
    store_word(8, load_value('h210, MEM_WORD, 1'b0));
    load_into(9, 'h214, 2, MEM_WORD);
    emit(enc_i(1, 9, 0, 10, OP_IMM));
    store_word(10, golden_word('h214) + 1);
    emit(HALT_INST);
    // Byte and half stores at each lane, then merged read back
    cur = 4;
    st_addr = 'h100;
    load_const(1, c);
    for (int l = 0; l < 4; l++) begin
      emit(enc_s('h300 + l, 1, 0, 0));
      expect_store('h300 + l, MEM_BYTE, word_t'(c[7:0]) << (8 * l));
    end
    for (int l = 0; l < 4; l += 2) begin
      emit(enc_s('h304 + l, 1, 0, 1));
      expect_store('h304 + l, MEM_HALF, word_t'(c[15:0]) << (8 * l));
    end
    emit(enc_s('h311, 1, 0, 0));
    expect_store('h311, MEM_BYTE, word_t'(c[7:0]) << 8);
    load_into(11, 'h300, 2, MEM_WORD);
    store_word(11, {4{c[7:0]}});
    load_into(11, 'h304, 2, MEM_WORD);
    store_word(11, {2{c[15:0]}});
    m = golden_word('h310);
    m[15:8] = c[7:0];
    load_into(11, 'h310, 2, MEM_WORD);
    store_word(11, m);
    emit(HALT_INST);
    // Stores behind the halt never reach the data port
    cur = 5;
    st_addr = 'h100;
    emit(enc_i('h55, 0, 0, 1, OP_IMM));
    store_word(1, 32'h0000_0055);
    emit(HALT_INST);
    emit(enc_s('h104, 1, 0, 2));
    emit(enc_s('h108, 1, 0, 2));
  endtask

  task automatic run_test(int t);
    int cycles;
    @(posedge clk);
    #1;
    nrst = 1'b0;
    cur = t;
    repeat (2) @(posedge clk);
    #1;
    nrst = 1'b1;
    @(negedge clk);
    check("iaddr", iaddr, PC_INIT);
    check("dwrite", word_t'(dwrite), word_t'(MEM_NONE));
    check("halt", word_t'(halt), 0);
    cycles = 0;
    while (halt !== 1'b1) begin
      @(negedge clk);
      cycles++;
      if (cycles > limit) begin
        $display("Test %0d timed out, halt did not rise within %0d cycles", t, limit);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped on timeout");
      end
    end
    // Halt holds and nothing else gets stored
    repeat (8) begin
      @(negedge clk);
      check("halt", word_t'(halt), 1);
    end
    check("store count", got_addr.size(), exp_cnt[t]);
    for (int k = 0; k < exp_cnt[t]; k++) begin
      check("daddr", got_addr[k], exp_addr[t][k]);
      check("dwrite", word_t'(got_size[k]), word_t'(exp_size[t][k]));
      check("dstore", got_data[k], exp_data[t][k]);
    end
    check("load count", got_raddr.size(), exp_rcnt[t]);
    for (int k = 0; k < exp_rcnt[t]; k++) begin
      check("daddr", got_raddr[k], exp_raddr[t][k]);
      check("dread", word_t'(got_rsize[k]), word_t'(exp_rsize[t][k]));
    end
  endtask

  initial begin
    word_t r;
    nrst = 1'b0;
    r = 32'hea82;
    for (int a = 0; a < 4096; a += 4) begin
      r = xorshift(r);
      {golden[a+3], golden[a+2], golden[a+1], golden[a]} = r;
    end
    build_tests();
    limit = 0;
    for (int t = 0; t < NTEST; t++) begin
      if (4 * prog_len[t] + 50 > limit) begin
        limit = 4 * prog_len[t] + 50;
      end
    end
    for (int t = 0; t < NTEST; t++) begin
      run_test(t);
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: list.f
source/core_pkg.sv
source/fetch_stage.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/writeback_stage.sv
source/pipeline_top.sv
tb/pipeline_checker.sv
tb/pipeline_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timescale 1ns/1ps --top-module pipeline_tb -f list.f -o pipeline_sim
./obj_dir/pipeline_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "SOME TESTS FAILED" sim.log; then
  echo "Simulation failed"
  exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"
